// File: verilog/dbg_axi_pkg.sv
// Debug AXI bridge definitions
package dbg_axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Fixed 64-bit data bus with 32-bit addressing
  parameter int AXI_ADDR_WIDTH = 32;
  parameter int AXI_DATA_WIDTH = 64;
  // One strobe per byte lane
  parameter int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
  parameter int AXI_ID_WIDTH   = 3;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Access size as sent by the debug transport, in bytes
  typedef enum logic [3:0]
  {
    SZ_BYTE  = 4'd1,
    SZ_HALF  = 4'd2,
    SZ_WORD  = 4'd4,
    SZ_DWORD = 4'd8
  } dbg_size_e;

  // AXI AxSIZE code, log2 of the byte count
  typedef enum logic [2:0]
  {
    AXI_SIZE_BYTE  = 3'd0,
    AXI_SIZE_HALF  = 3'd1,
    AXI_SIZE_WORD  = 3'd2,
    AXI_SIZE_DWORD = 3'd3
  } axi_size_e;

  // AXI BRESP / RRESP
  typedef enum logic [1:0]
  {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Master FSM, one state per AXI phase
  typedef enum logic [1:0]
  {
    S_IDLE = 2'd0,
    S_ADDR = 2'd1,
    S_DATA = 2'd2,
    S_RESP = 2'd3
  } axi_fsm_e;

  //////////////////////////////////////////////////////////////////////
  // Request and channel payloads
  //////////////////////////////////////////////////////////////////////

  // Request as captured in the tck domain, held until the access ends
  typedef struct packed
  {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    axi_size_e                 size;
    logic                      wr;
  } dbg_req_t;

  // AW and AR share one layout
  typedef struct packed
  {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    axi_size_e                 size;
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [2:0]                prot;
  } axi_ax_t;

  typedef struct packed
  {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed
  {
    axi_resp_e               resp;
    logic [AXI_ID_WIDTH-1:0] id;
  } axi_b_t;

  typedef struct packed
  {
    logic [AXI_DATA_WIDTH-1:0] data;
    axi_resp_e                 resp;
    logic                      last;
    logic [AXI_ID_WIDTH-1:0]   id;
  } axi_r_t;

endpackage

// File: verilog/toggle_sync.sv
// Toggle synchronizer
`timescale 1ns/10ps

module toggle_sync
#(
  // Needs at least two stages
  parameter int SYNC_STAGES = 2
)
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic tgl_i,
  output logic pulse_o
);

  // Metastability chain, bit 0 samples the foreign toggle
  logic [SYNC_STAGES-1:0] sync_q;
  // Last settled level, for edge detection
  logic                   hist_q;

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      sync_q <= '0;
      hist_q <= 1'b0;
    end
    else
    begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], tgl_i};
      hist_q <= sync_q[SYNC_STAGES-1];
    end
  end

  // High for one cycle on each settled change of the toggle
  assign pulse_o = sync_q[SYNC_STAGES-1] ^ hist_q;

endmodule

// File: verilog/dbg_lane_decode.sv
// Byte lane decoder
`timescale 1ns/10ps

module dbg_lane_decode
  import dbg_axi_pkg::*;
(
  input  dbg_size_e                 size_i,
  input  logic [2:0]                addr_low_i,
  input  logic [AXI_DATA_WIDTH-1:0] data_i,
  output logic [AXI_STRB_WIDTH-1:0] strb_o,
  output axi_size_e                 axi_size_o,
  output logic [AXI_DATA_WIDTH-1:0] wdata_o
);

  // Strobe pattern before it is moved to its lane group
  logic [AXI_STRB_WIDTH-1:0] lane_mask;
  // First byte lane of the naturally aligned group
  logic [2:0]                lane_base;
  // Bits to drop from data_i so the value sits at bit 0
  logic [6:0]                top_shift;
  // Bit offset of the lane group inside the bus
  logic [5:0]                lane_shift;

  // Size decode, unknown codes fall back to a full dword
  always_comb
  begin
    case (size_i)
      SZ_BYTE:
      begin
        axi_size_o = AXI_SIZE_BYTE;
        lane_mask  = 8'b0000_0001;
        lane_base  = addr_low_i;
        top_shift  = 7'd56;
      end
      SZ_HALF:
      begin
        axi_size_o = AXI_SIZE_HALF;
        lane_mask  = 8'b0000_0011;
        lane_base  = {addr_low_i[2:1], 1'b0};
        top_shift  = 7'd48;
      end
      SZ_WORD:
      begin
        axi_size_o = AXI_SIZE_WORD;
        lane_mask  = 8'b0000_1111;
        lane_base  = {addr_low_i[2], 2'b00};
        top_shift  = 7'd32;
      end
      default:
      begin
        axi_size_o = AXI_SIZE_DWORD;
        lane_mask  = 8'b1111_1111;
        lane_base  = 3'd0;
        top_shift  = 7'd0;
      end
    endcase
  end

  assign lane_shift = {lane_base, 3'b000};
  assign strb_o     = lane_mask << lane_base;

  // Value arrives left-justified in data_i
  // Drop it to bit 0, then lift it into its lanes
  assign wdata_o = (data_i >> top_shift) << lane_shift;

endmodule

// File: verilog/dbg_req_capture.sv
// Debug request capture
`timescale 1ns/10ps

module dbg_req_capture
  import dbg_axi_pkg::*;
(
  input  logic                      tck_i,
  input  logic                      trstn_i,
  input  logic [AXI_ADDR_WIDTH-1:0] addr_i,
  input  logic [AXI_DATA_WIDTH-1:0] data_i,
  // Low selects a write
  input  logic                      rd_wrn_i,
  input  logic [3:0]                word_size_i,
  input  logic                      strobe_i,
  // Completion seen in the tck domain
  input  logic                      done_pulse_i,
  output dbg_req_t                  req_o,
  output logic                      start_tgl_o,
  output logic                      rdy_o
);

  logic                      accept;
  logic [AXI_STRB_WIDTH-1:0] dec_strb;
  axi_size_e                 dec_size;
  logic [AXI_DATA_WIDTH-1:0] dec_wdata;

  // Strobe only counts while idle
  assign accept = strobe_i & rdy_o;

  //////////////////////////////////////////////////////////////////////
  // Lane decode of the incoming request
  //////////////////////////////////////////////////////////////////////

  dbg_lane_decode u_lane_decode
  (
    .size_i     (dbg_size_e'(word_size_i)),
    .addr_low_i (addr_i[2:0]),
    .data_i     (data_i),
    .strb_o     (dec_strb),
    .axi_size_o (dec_size),
    .wdata_o    (dec_wdata)
  );

  // Request payload
  // Held stable while the AXI side reads it without synchronizers
  always_ff @(posedge tck_i)
  begin
    if (accept)
    begin
      req_o.addr  <= addr_i;
      req_o.strb  <= dec_strb;
      req_o.wdata <= dec_wdata;
      req_o.size  <= dec_size;
      req_o.wr    <= ~rd_wrn_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake toward the AXI domain
  //////////////////////////////////////////////////////////////////////

  // Each flip starts one AXI transaction
  always_ff @(posedge tck_i, negedge trstn_i)
  begin
    if (!trstn_i)
      start_tgl_o <= 1'b0;
    else if (accept)
      start_tgl_o <= ~start_tgl_o;
  end

  // Ready drops on acceptance, returns when the done toggle arrives
  always_ff @(posedge tck_i, negedge trstn_i)
  begin
    if (!trstn_i)
      rdy_o <= 1'b1;
    else if (accept)
      rdy_o <= 1'b0;
    else if (done_pulse_i)
      rdy_o <= 1'b1;
  end

endmodule

// File: verilog/axi_single_master.sv
// Single-beat AXI4 master
`timescale 1ns/10ps

module axi_single_master
  import dbg_axi_pkg::*;
#(
  parameter int AXI_ID = 4
)
(
  input  logic                      axi_aclk,
  input  logic                      axi_aresetn,
  input  logic                      start_pulse_i,
  // Captured in the tck domain, stable for the whole access
  input  dbg_req_t                  req_i,
  output axi_ax_t                   aw_o,
  output logic                      aw_valid_o,
  input  logic                      aw_ready_i,
  output axi_w_t                    w_o,
  output logic                      w_valid_o,
  input  logic                      w_ready_i,
  input  axi_b_t                    b_i,
  input  logic                      b_valid_i,
  output logic                      b_ready_o,
  output axi_ax_t                   ar_o,
  output logic                      ar_valid_o,
  input  logic                      ar_ready_i,
  input  axi_r_t                    r_i,
  input  logic                      r_valid_i,
  output logic                      r_ready_o,
  output logic [AXI_DATA_WIDTH-1:0] rdata_o,
  output logic                      err_o,
  output logic                      done_tgl_o
);

  axi_fsm_e  state_q;
  axi_fsm_e  state_d;
  axi_ax_t   ax_pl;
  axi_resp_e resp_sel;
  logic      complete;
  // Lowest strobed lane, i.e. the byte offset of the access
  logic [2:0] low_lane;

  //////////////////////////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////////////////////////

  // Same address beat for both directions, unprivileged and secure
  assign ax_pl.addr = req_i.addr;
  assign ax_pl.size = req_i.size;
  assign ax_pl.id   = AXI_ID_WIDTH'(AXI_ID);
  assign ax_pl.prot = 3'b000;
  assign aw_o       = ax_pl;
  assign ar_o       = ax_pl;

  // Always a single beat
  assign w_o.data = req_i.wdata;
  assign w_o.strb = req_i.strb;
  assign w_o.last = 1'b1;

  // Valids and readies follow the state directly
  assign aw_valid_o = (state_q == S_ADDR) &&  req_i.wr;
  assign ar_valid_o = (state_q == S_ADDR) && !req_i.wr;
  assign w_valid_o  = (state_q == S_DATA);
  assign b_ready_o  = (state_q == S_RESP) &&  req_i.wr;
  assign r_ready_o  = (state_q == S_RESP) && !req_i.wr;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
        if (start_pulse_i)
          state_d = S_ADDR;
      S_ADDR:
      begin
        // Writes go on to W, reads wait for R
        if (req_i.wr && aw_ready_i)
          state_d = S_DATA;
        else if (!req_i.wr && ar_ready_i)
          state_d = S_RESP;
      end
      S_DATA:
        if (w_ready_i)
          state_d = S_RESP;
      default:
        if (complete)
          state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge axi_aclk, negedge axi_aresetn)
  begin
    if (!axi_aresetn)
      state_q <= S_IDLE;
    else
      state_q <= state_d;
  end

  // Response handshake of whichever channel is in use
  assign complete = (state_q == S_RESP) && (req_i.wr ? b_valid_i : r_valid_i);
  assign resp_sel = req_i.wr ? b_i.resp : r_i.resp;

  //////////////////////////////////////////////////////////////////////
  // Completion and read alignment
  //////////////////////////////////////////////////////////////////////

  // Scan from the top so the lowest set strobe wins
  always_comb
  begin
    low_lane = 3'd0;
    for (int i = AXI_STRB_WIDTH - 1; i >= 0; i--)
      if (req_i.strb[i])
        low_lane = 3'(i);
  end

  always_ff @(posedge axi_aclk, negedge axi_aresetn)
  begin
    if (!axi_aresetn)
    begin
      rdata_o    <= '0;
      err_o      <= 1'b0;
      done_tgl_o <= 1'b0;
    end
    else if (complete)
    begin
      // Read data right-aligned, upper bytes zero filled
      if (!req_i.wr)
        rdata_o <= r_i.data >> {low_lane, 3'b000};
      err_o      <= (resp_sel != OKAY);
      done_tgl_o <= ~done_tgl_o;
    end
  end

endmodule

// File: verilog/dbg_axi_biu.sv
// Debug to AXI bus interface
`timescale 1ns/10ps

module dbg_axi_biu
  import dbg_axi_pkg::*;
#(
  parameter int AXI_ID      = 4,
  parameter int SYNC_STAGES = 2
)
(
  // Debug transport, tck domain
  input  logic                      tck_i,
  input  logic                      trstn_i,
  input  logic [AXI_ADDR_WIDTH-1:0] addr_i,
  input  logic [AXI_DATA_WIDTH-1:0] data_i,
  input  logic                      rd_wrn_i,
  input  logic [3:0]                word_size_i,
  input  logic                      strobe_i,
  output logic [AXI_DATA_WIDTH-1:0] data_o,
  output logic                      rdy_o,
  output logic                      err_o,
  // AXI4 master
  input  logic                      axi_aclk,
  input  logic                      axi_aresetn,
  output axi_ax_t                   aw_o,
  output logic                      aw_valid_o,
  input  logic                      aw_ready_i,
  output axi_w_t                    w_o,
  output logic                      w_valid_o,
  input  logic                      w_ready_i,
  input  axi_b_t                    b_i,
  input  logic                      b_valid_i,
  output logic                      b_ready_o,
  output axi_ax_t                   ar_o,
  output logic                      ar_valid_o,
  input  logic                      ar_ready_i,
  input  axi_r_t                    r_i,
  input  logic                      r_valid_i,
  output logic                      r_ready_o
);

  dbg_req_t req;
  logic     start_tgl;
  logic     start_pulse;
  logic     done_tgl;
  logic     done_pulse;

  //////////////////////////////////////////////////////////////////////
  // tck domain
  //////////////////////////////////////////////////////////////////////

  dbg_req_capture u_capture
  (
    .tck_i        (tck_i),
    .trstn_i      (trstn_i),
    .addr_i       (addr_i),
    .data_i       (data_i),
    .rd_wrn_i     (rd_wrn_i),
    .word_size_i  (word_size_i),
    .strobe_i     (strobe_i),
    .done_pulse_i (done_pulse),
    .req_o        (req),
    .start_tgl_o  (start_tgl),
    .rdy_o        (rdy_o)
  );

  // Completion back into tck
  toggle_sync #(.SYNC_STAGES(SYNC_STAGES)) u_done_sync
  (
    .clk_i   (tck_i),
    .rst_ni  (trstn_i),
    .tgl_i   (done_tgl),
    .pulse_o (done_pulse)
  );

  //////////////////////////////////////////////////////////////////////
  // axi_aclk domain
  //////////////////////////////////////////////////////////////////////

  // Start request into axi_aclk
  toggle_sync #(.SYNC_STAGES(SYNC_STAGES)) u_start_sync
  (
    .clk_i   (axi_aclk),
    .rst_ni  (axi_aresetn),
    .tgl_i   (start_tgl),
    .pulse_o (start_pulse)
  );

  // data_o and err_o settle before done_pulse raises rdy_o
  axi_single_master #(.AXI_ID(AXI_ID)) u_master
  (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .start_pulse_i (start_pulse),
    .req_i         (req),
    .aw_o          (aw_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .w_o           (w_o),
    .w_valid_o     (w_valid_o),
    .w_ready_i     (w_ready_i),
    .b_i           (b_i),
    .b_valid_i     (b_valid_i),
    .b_ready_o     (b_ready_o),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .r_i           (r_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .rdata_o       (data_o),
    .err_o         (err_o),
    .done_tgl_o    (done_tgl)
  );

endmodule

// File: verification/axi_mem_model.sv
// AXI slave memory model
`timescale 1ns/10ps

module axi_mem_model
  import dbg_axi_pkg::*;
#(
  parameter int unsigned                SEED     = 1,
  // First address of the region that answers SLVERR
  parameter logic [AXI_ADDR_WIDTH-1:0] ERR_BASE = 32'h0000_F000
)
(
  input  logic    axi_aclk,
  input  logic    axi_aresetn,
  input  axi_ax_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,
  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i,
  input  axi_ax_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  // Sparse storage, one entry per 64-bit word
  logic [AXI_DATA_WIDTH-1:0] mem [logic [AXI_ADDR_WIDTH-4:0]];

  // Content of a word never written, unique per word address
  function automatic logic [AXI_DATA_WIDTH-1:0] fill_word(input logic [AXI_ADDR_WIDTH-4:0] idx);
    return {3'b101, idx, ~{3'b101, idx}};
  endfunction

  // Stall of 0 to 3 cycles before a ready or valid
  task automatic random_delay();
    int unsigned n;
    n = $urandom % 4;
    repeat (n) @(posedge axi_aclk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // One transaction at a time, inputs sampled on the clock edge
  //////////////////////////////////////////////////////////////////////

  initial
  begin : serve
    axi_ax_t                   ax;
    axi_w_t                    w;
    logic [AXI_ADDR_WIDTH-4:0] idx;
    logic [AXI_DATA_WIDTH-1:0] word;
    logic                      bad;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    b_o        = '0;
    r_o        = '0;
    void'($urandom(SEED));
    wait (axi_aresetn);
    forever
    begin
      @(posedge axi_aclk);
      if (aw_valid_i)
      begin
        // Address phase of a write
        random_delay();
        aw_ready_o <= 1'b1;
        @(posedge axi_aclk);
        ax = aw_i;
        aw_ready_o <= 1'b0;
        // Data phase
        do
          @(posedge axi_aclk);
        while (!w_valid_i);
        random_delay();
        w_ready_o <= 1'b1;
        @(posedge axi_aclk);
        w = w_i;
        w_ready_o <= 1'b0;
        // Merge by strobe outside the error window
        bad = (ax.addr >= ERR_BASE);
        idx = ax.addr[AXI_ADDR_WIDTH-1:3];
        if (!bad)
        begin
          word = mem.exists(idx) ? mem[idx] : fill_word(idx);
          for (int i = 0; i < AXI_STRB_WIDTH; i++)
            if (w.strb[i])
              word[8*i +: 8] = w.data[8*i +: 8];
          mem[idx] = word;
        end
        // Write response
        random_delay();
        b_o.resp  <= bad ? SLVERR : OKAY;
        b_o.id    <= ax.id;
        b_valid_o <= 1'b1;
        do
          @(posedge axi_aclk);
        while (!b_ready_i);
        b_valid_o <= 1'b0;
      end
      else if (ar_valid_i)
      begin
        // Address phase of a read
        random_delay();
        ar_ready_o <= 1'b1;
        @(posedge axi_aclk);
        ax = ar_i;
        ar_ready_o <= 1'b0;
        bad = (ax.addr >= ERR_BASE);
        idx = ax.addr[AXI_ADDR_WIDTH-1:3];
        // Whole aligned word goes back, the master picks the lanes
        random_delay();
        if (bad)
          r_o.data <= '0;
        else
          r_o.data <= mem.exists(idx) ? mem[idx] : fill_word(idx);
        r_o.resp  <= bad ? SLVERR : OKAY;
        r_o.last  <= 1'b1;
        r_o.id    <= ax.id;
        r_valid_o <= 1'b1;
        do
          @(posedge axi_aclk);
        while (!r_ready_i);
        r_valid_o <= 1'b0;
      end
    end
  end

endmodule

// File: verification/dbg_axi_biu_props.sv
// AXI handshake assertions
`timescale 1ns/10ps

module dbg_axi_biu_props
  import dbg_axi_pkg::*;
(
  input logic    axi_aclk,
  input logic    axi_aresetn,
  input axi_ax_t aw_o,
  input logic    aw_valid_o,
  input logic    aw_ready_i,
  input axi_w_t  w_o,
  input logic    w_valid_o,
  input logic    w_ready_i,
  input logic    b_valid_i,
  input logic    b_ready_o,
  input axi_ax_t ar_o,
  input logic    ar_valid_o,
  input logic    ar_ready_i
);

  // Set between the AW handshake and the B handshake
  logic        aw_open_q;
  // Number of assertion failures so far
  int unsigned fail_total = 0;

  always_ff @(posedge axi_aclk, negedge axi_aresetn)
  begin
    if (!axi_aresetn)
      aw_open_q <= 1'b0;
    else if (aw_valid_o && aw_ready_i)
      aw_open_q <= 1'b1;
    else if (b_valid_i && b_ready_o)
      aw_open_q <= 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Valid held with a stable payload until ready
  //////////////////////////////////////////////////////////////////////

  aw_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
  else
  begin
    $error("AW valid dropped or payload changed before ready");
    fail_total++;
  end

  w_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
  else
  begin
    $error("W valid dropped or payload changed before ready");
    fail_total++;
  end

  ar_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
  else
  begin
    $error("AR valid dropped or payload changed before ready");
    fail_total++;
  end

  // Only one transaction in flight
  aw_ar_excl: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    (aw_valid_o || ar_valid_o) |-> !(aw_valid_o && ar_valid_o) && !aw_open_q)
  else
  begin
    $error("AW and AR valid together or while a write is open");
    fail_total++;
  end

  w_after_aw: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    w_valid_o |-> aw_open_q)
  else
  begin
    $error("W valid without an accepted AW");
    fail_total++;
  end

endmodule

bind axi_single_master dbg_axi_biu_props u_props (.*);

// File: verification/dbg_axi_biu_tb.sv
// Debug AXI bridge testbench
`timescale 1ns/10ps

module dbg_axi_biu_tb
  import dbg_axi_pkg::*;
();

  localparam int          AXI_ID      = 4;
  localparam int          SYNC_STAGES = 2;
  localparam int unsigned SEED        = 89440;
  localparam logic [31:0] ERR_BASE    = 32'h0000_F000;

  // One table row: access, its value and the expected error flag
  typedef struct packed
  {
    logic        wr;
    dbg_size_e   size;
    logic [31:0] addr;
    logic [63:0] value;
    logic        err;
  } vector_t;

  logic        tck;
  logic        trstn;
  logic [31:0] dbg_addr;
  logic [63:0] dbg_wdata;
  logic        rd_wrn;
  logic [3:0]  word_size;
  logic        strobe;
  logic [63:0] dbg_rdata;
  logic        rdy;
  logic        err;
  logic        axi_aclk;
  logic        axi_aresetn;
  axi_ax_t     aw;
  axi_ax_t     ar;
  axi_w_t      w;
  axi_b_t      b;
  axi_r_t      r;
  logic        aw_valid;
  logic        aw_ready;
  logic        w_valid;
  logic        w_ready;
  logic        b_valid;
  logic        b_ready;
  logic        ar_valid;
  logic        ar_ready;
  logic        r_valid;
  logic        r_ready;

  vector_t     vectors[$];
  // Access in progress, seen by the beat monitor
  vector_t     cur;
  // Expected memory content, word address to data
  logic [63:0] shadow [logic [28:0]];

  dbg_axi_biu #(.AXI_ID(AXI_ID), .SYNC_STAGES(SYNC_STAGES)) uut
  (
    .tck_i       (tck),
    .trstn_i     (trstn),
    .addr_i      (dbg_addr),
    .data_i      (dbg_wdata),
    .rd_wrn_i    (rd_wrn),
    .word_size_i (word_size),
    .strobe_i    (strobe),
    .data_o      (dbg_rdata),
    .rdy_o       (rdy),
    .err_o       (err),
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .aw_o        (aw),
    .aw_valid_o  (aw_valid),
    .aw_ready_i  (aw_ready),
    .w_o         (w),
    .w_valid_o   (w_valid),
    .w_ready_i   (w_ready),
    .b_i         (b),
    .b_valid_i   (b_valid),
    .b_ready_o   (b_ready),
    .ar_o        (ar),
    .ar_valid_o  (ar_valid),
    .ar_ready_i  (ar_ready),
    .r_i         (r),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready)
  );

  axi_mem_model #(.SEED(SEED), .ERR_BASE(ERR_BASE)) u_mem
  (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .aw_i        (aw),
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .w_i         (w),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .b_o         (b),
    .b_valid_o   (b_valid),
    .b_ready_i   (b_ready),
    .ar_i        (ar),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .r_o         (r),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Clocks
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    axi_aclk = 1'b0;
    forever #2 axi_aclk = ~axi_aclk;
  end

  initial
  begin
    tck = 1'b0;
    forever #5 tck = ~tck;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic add_vector(input logic wr, input dbg_size_e size, input logic [31:0] addr,
                            input logic [63:0] value, input logic err);
    vector_t v;
    v.wr    = wr;
    v.size  = size;
    v.addr  = addr;
    v.value = value;
    v.err   = err;
    vectors.push_back(v);
  endtask

  // Mask of the low size bytes
  function automatic logic [63:0] size_mask(input int s);
    return (s >= 8) ? '1 : ((64'd1 << (8 * s)) - 1);
  endfunction

  // Byte offset of the naturally aligned lane group
  function automatic int lane_offset(input logic [31:0] addr, input int s);
    return int'(addr[2:0]) & ~(s - 1);
  endfunction

  // AxSIZE is log2 of the byte count
  function automatic logic [2:0] size_code(input int s);
    return 3'($clog2(s));
  endfunction

  // One strobe per byte of the addressed lane group
  function automatic logic [7:0] lane_strobes(input logic [31:0] addr, input int s);
    return 8'(((16'd1 << s) - 1) << lane_offset(addr, s));
  endfunction

  // Value left-justified, filler in the unused low bits
  function automatic logic [63:0] place_value(input logic [63:0] value, input int s);
    logic [63:0] filler;
    filler = 64'h5A5A_C3C3_0F0F_9696 & ((64'd1 << (64 - 8 * s)) - 1);
    return (value << (64 - 8 * s)) | filler;
  endfunction

  function automatic void shadow_write(input logic [31:0] addr, input int s,
                                       input logic [63:0] value);
    logic [63:0] word;
    int          off;
    word = shadow.exists(addr[31:3]) ? shadow[addr[31:3]] : '0;
    off  = lane_offset(addr, s);
    for (int k = 0; k < s; k++)
      word[8*(off+k) +: 8] = value[8*k +: 8];
    shadow[addr[31:3]] = word;
  endfunction

  // Aligned word shifted down by the lane offset
  function automatic logic [63:0] expected_read(input logic [31:0] addr, input int s);
    logic [63:0] word;
    word = shadow.exists(addr[31:3]) ? shadow[addr[31:3]] : '0;
    return (word >> (8 * lane_offset(addr, s))) & size_mask(s);
  endfunction

  // AW or AR payload of the access in progress
  task automatic check_addr_beat(input string chan, input axi_ax_t ax, input logic is_wr);
    check_value({chan, " direction"}, is_wr, cur.wr);
    check_value({chan, " address"}, ax.addr, cur.addr);
    check_value({chan, " size"}, ax.size, size_code(int'(cur.size)));
    check_value({chan, " id"}, ax.id, AXI_ID);
    check_value({chan, " prot"}, ax.prot, 3'b000);
  endtask

  // Inputs change 1 ns after tck rises, rdy_o sampled at the same point
  task automatic run_access(input vector_t v);
    @(posedge tck);
    #1;
    dbg_addr  = v.addr;
    dbg_wdata = place_value(v.value, int'(v.size));
    rd_wrn    = ~v.wr;
    word_size = v.size;
    strobe    = 1'b1;
    @(posedge tck);
    #1;
    strobe = 1'b0;
    do
    begin
      @(posedge tck);
      #1;
    end
    while (!rdy);
  endtask

  task automatic build_table();
    // Dword round trip
    add_vector(1'b1, SZ_DWORD, 32'h0100, 64'h0123_4567_89AB_CDEF, 1'b0);
    add_vector(1'b0, SZ_DWORD, 32'h0100, '0, 1'b0);
    // Byte lanes merged into one word
    add_vector(1'b1, SZ_DWORD, 32'h0200, 64'h1111_2222_3333_4444, 1'b0);
    for (int k = 0; k < 8; k += 2)
      add_vector(1'b1, SZ_BYTE, 32'h0200 + k, 64'hA0 + k, 1'b0);
    for (int k = 0; k < 8; k++)
      add_vector(1'b0, SZ_BYTE, 32'h0200 + k, '0, 1'b0);
    add_vector(1'b0, SZ_DWORD, 32'h0200, '0, 1'b0);
    // Halfword lanes
    add_vector(1'b1, SZ_DWORD, 32'h0208, 64'hFFFF_EEEE_DDDD_CCCC, 1'b0);
    for (int k = 0; k < 8; k += 4)
      add_vector(1'b1, SZ_HALF, 32'h0208 + k, 64'hB000 + k, 1'b0);
    for (int k = 0; k < 8; k += 2)
      add_vector(1'b0, SZ_HALF, 32'h0208 + k, '0, 1'b0);
    add_vector(1'b0, SZ_DWORD, 32'h0208, '0, 1'b0);
    // Word writes, then byte reads of every lane
    add_vector(1'b1, SZ_WORD, 32'h0300, 64'h89AB_CDEF, 1'b0);
    add_vector(1'b1, SZ_WORD, 32'h0304, 64'h7654_3210, 1'b0);
    for (int k = 0; k < 8; k++)
      add_vector(1'b0, SZ_BYTE, 32'h0300 + k, '0, 1'b0);
    add_vector(1'b0, SZ_WORD, 32'h0304, '0, 1'b0);
    // Error window, each followed by a good access
    add_vector(1'b1, SZ_DWORD, ERR_BASE, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1);
    add_vector(1'b0, SZ_DWORD, 32'h0100, '0, 1'b0);
    add_vector(1'b0, SZ_DWORD, ERR_BASE + 32'h8, '0, 1'b1);
    add_vector(1'b1, SZ_BYTE, 32'h0301, 64'h3C, 1'b0);
    add_vector(1'b0, SZ_WORD, 32'h0300, '0, 1'b0);
    // Back-to-back pairs under random stalls
    for (int k = 0; k < 8; k++)
    begin
      add_vector(1'b1, SZ_DWORD, 32'h0400 + 8 * k, {8{8'(k * 37 + 5)}} ^ 64'(k), 1'b0);
      add_vector(1'b0, SZ_DWORD, 32'h0400 + 8 * k, '0, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI beat monitor
  //////////////////////////////////////////////////////////////////////

  // Valid and ready both high mid-cycle means a handshake at the next edge
  always @(negedge axi_aclk)
  begin
    if (aw_valid && aw_ready)
      check_addr_beat("AW", aw, 1'b1);
    if (ar_valid && ar_ready)
      check_addr_beat("AR", ar, 1'b0);
    if (w_valid && w_ready)
    begin
      check_value("W strobes", w.strb, lane_strobes(cur.addr, int'(cur.size)));
      check_value("W last", w.last, 1'b1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin : main
    vector_t     v;
    logic [63:0] mask;
    trstn       = 1'b0;
    axi_aresetn = 1'b0;
    dbg_addr    = '0;
    dbg_wdata   = '0;
    rd_wrn      = 1'b1;
    word_size   = 4'd8;
    strobe      = 1'b0;
    build_table();
    repeat (5) @(posedge axi_aclk);
    #1;
    trstn       = 1'b1;
    axi_aresetn = 1'b1;
    check_value("rdy_o after reset", rdy, 1'b1);
    check_value("err_o after reset", err, 1'b0);
    check_value("data_o after reset", dbg_rdata, '0);
    check_value("AXI valids and readies after reset",
                {aw_valid, w_valid, ar_valid, b_ready, r_ready}, '0);
    foreach (vectors[n])
    begin
      v   = vectors[n];
      cur = v;
      run_access(v);
      check_value($sformatf("entry %0d err_o", n), err, v.err);
      if (!v.err)
      begin
        if (v.wr)
          shadow_write(v.addr, int'(v.size), v.value);
        else
        begin
          mask = size_mask(int'(v.size));
          check_value($sformatf("entry %0d read at %h", n, v.addr), dbg_rdata & mask,
                      expected_read(v.addr, int'(v.size)));
        end
      end
    end
    if (uut.u_master.u_props.fail_total == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // Stop at the first failed handshake assertion
  initial
  begin : assertion_watch
    wait (uut.u_master.u_props.fail_total != 0);
    $display("An AXI handshake assertion failed at %0t ns", $time);
    $display("Simulation finished: FAIL");
    $fatal(1, "Assertion failure");
  end

  // Limit scales with the table length
  initial
  begin : watchdog
    int unsigned limit;
    #1;
    limit = vectors.size() * 200;
    repeat (limit) @(posedge axi_aclk);
    $display("Timeout: the access table did not finish within %0d axi_aclk cycles", limit);
    $display("Simulation finished: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: dbg_axi_biu.f
verilog/dbg_axi_pkg.sv
verilog/toggle_sync.sv
verilog/dbg_lane_decode.sv
verilog/dbg_req_capture.sv
verilog/axi_single_master.sv
verilog/dbg_axi_biu.sv
verification/axi_mem_model.sv
verification/dbg_axi_biu_props.sv
verification/dbg_axi_biu_tb.sv
